//--- cache_ram.sv
`timescale 1ns/1ps

module cache_ram #(
    parameter int unsigned WIDTH = 28,
    parameter int unsigned DEPTH = 128
) (
    input  logic                     clk,
    input  logic [$clog2(DEPTH)-1:0] rd_addr_i,
    output logic [WIDTH-1:0]         rd_data_o,
    input  logic [$clog2(DEPTH)-1:0] rw_addr_i,
    input  logic                     we_i,
    input  logic [WIDTH-1:0]         wdata_i,
    output logic [WIDTH-1:0]         rw_data_o
);

    logic [WIDTH-1:0] mem_q [DEPTH];

    // read-first on both ports, read data one cycle after the address
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem_q[rw_addr_i] <= wdata_i;
        end
        rw_data_o <= mem_q[rw_addr_i];
        rd_data_o <= mem_q[rd_addr_i];
    end

endmodule

//--- fetch_pc_gen.sv
`timescale 1ns/1ps

module fetch_pc_gen (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   redirect_i,
    input  logic [31:0]            redirect_pc_i,
    input  logic                   req_ready_i,
    input  logic                   space_i,
    output icache_pkg::fetch_req_t req_o,
    output logic                   req_valid_o
);

    logic [31:0] pc_q;
    logic        run_q;
    logic        fire;

    // no request until the cycle after reset, and only with buffer room
    assign req_valid_o = run_q && space_i;
    assign fire        = req_valid_o && req_ready_i;

    assign req_o.pc   = pc_q;
    // odd word start only fills the upper slot
    assign req_o.mask = pc_q[2] ? 2'b10 : 2'b11;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q  <= '0;
            run_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
            if (redirect_i) begin
                pc_q <= {redirect_pc_i[31:2], 2'b00};
            end else if (fire) begin
                // next 8-byte boundary
                pc_q <= {pc_q[31:3] + 29'd1, 3'b000};
            end
        end
    end

endmodule

//--- icache.sv
`timescale 1ns/1ps

module icache #(
    parameter int unsigned SET_NUM = 128
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   flush_i,
    input  icache_pkg::fetch_req_t req_i,
    input  logic                   req_valid_i,
    output logic                   req_ready_o,
    output icache_pkg::fetch_pkt_t pkt_o,
    output logic                   pkt_valid_o,
    output logic                   mem_req_o,
    output logic [31:0]            mem_addr_o,
    input  logic                   mem_ack_i,
    input  logic                   mem_data_valid_i,
    input  logic [31:0]            mem_data_i,
    input  logic                   cacop_valid_i,
    input  icache_pkg::cacop_op_e  cacop_op_i,
    input  logic [31:0]            cacop_addr_i,
    output logic                   cacop_ready_o
);

    localparam int unsigned OFF_W   = $clog2(icache_pkg::LINE_BYTES);
    localparam int unsigned IDX_W   = $clog2(SET_NUM);
    localparam int unsigned PAIRS   = icache_pkg::LINE_WORDS / 2;
    localparam int unsigned PAIR_W  = $clog2(PAIRS);
    localparam int unsigned DADDR_W = IDX_W + PAIR_W;
    localparam int unsigned CNT_W   = $clog2(icache_pkg::LINE_WORDS);
    localparam int unsigned TAG_W   = $bits(icache_pkg::cache_tag_t);

    typedef enum logic [2:0] {
        S_NORMAL,
        S_MISS_REQ,
        S_REFILL,
        S_CACOP_RD,
        S_CACOP_WR
    } state_e;

    state_e                 state_q, state_d;
    icache_pkg::fetch_req_t lk_req_q;
    logic                   lk_valid_q;
    logic                   refill_done_q;
    logic [CNT_W-1:0]       word_cnt_q;
    logic [31:0]            pair_lo_q;
    logic [63:0]            pkt_buf_q;
    logic [SET_NUM-1:0]     repl_q;
    logic [IDX_W-1:0]       sweep_q;
    logic                   init_done_q;
    logic [31:0]            cacop_addr_q;

    logic [IDX_W-1:0]             rd_idx, miss_idx, tag_rw_idx;
    logic [DADDR_W-1:0]           rd_daddr, data_rw_addr;
    logic [1:0]                   tag_we, data_we, way_hit, cacop_hit;
    icache_pkg::cache_tag_t       tag_wdata;
    icache_pkg::cache_tag_t [1:0] tag_rd, tag_rw;
    logic [1:0][63:0]             data_rd;
    logic [63:0]                  data_wdata;
    logic                         victim, refill_last, cacop_fire, lk_hit, accept;

    assign rd_idx       = req_i.pc[OFF_W +: IDX_W];
    // pair address covers index and pair-in-line
    assign rd_daddr     = req_i.pc[3 +: DADDR_W];
    assign miss_idx     = lk_req_q.pc[OFF_W +: IDX_W];
    assign victim       = repl_q[miss_idx];
    assign data_rw_addr = {miss_idx, word_cnt_q[CNT_W-1:1]};
    assign data_wdata   = {mem_data_i, pair_lo_q};
    assign refill_last  = state_q == S_REFILL && mem_data_valid_i
                          && word_cnt_q == CNT_W'(icache_pkg::LINE_WORDS - 1);

    for (genvar w = 0; w < 2; w++) begin : g_way
        logic                   tag_fwd_q, data_fwd_q;
        icache_pkg::cache_tag_t tag_fwd_val_q;
        logic [63:0]            data_fwd_val_q;
        logic [TAG_W-1:0]       tag_rd_raw;
        logic [63:0]            data_rd_raw;

        cache_ram #(.WIDTH(TAG_W), .DEPTH(SET_NUM)) u_tag_ram (
            .clk       (clk),
            .rd_addr_i (rd_idx),
            .rd_data_o (tag_rd_raw),
            .rw_addr_i (tag_rw_idx),
            .we_i      (tag_we[w]),
            .wdata_i   (tag_wdata),
            .rw_data_o (tag_rw[w])
        );

        cache_ram #(.WIDTH(64), .DEPTH(SET_NUM * PAIRS)) u_data_ram (
            .clk       (clk),
            .rd_addr_i (rd_daddr),
            .rd_data_o (data_rd_raw),
            .rw_addr_i (data_rw_addr),
            .we_i      (data_we[w]),
            .wdata_i   (data_wdata),
            .rw_data_o ()
        );

        // same-cycle write to the address being read returns the new value
        always_ff @(posedge clk) begin
            tag_fwd_q      <= tag_we[w] && tag_rw_idx == rd_idx;
            data_fwd_q     <= data_we[w] && data_rw_addr == rd_daddr;
            tag_fwd_val_q  <= tag_wdata;
            data_fwd_val_q <= data_wdata;
        end

        assign tag_rd[w]    = tag_fwd_q ? tag_fwd_val_q : tag_rd_raw;
        assign data_rd[w]   = data_fwd_q ? data_fwd_val_q : data_rd_raw;
        assign way_hit[w]   = tag_rd[w].valid && tag_rd[w].tag == lk_req_q.pc[31:OFF_W];
        assign cacop_hit[w] = tag_rw[w].valid && tag_rw[w].tag == cacop_addr_q[31:OFF_W];
    end

    // refill result counts as a hit for the one cycle after the last word
    assign lk_hit        = refill_done_q || (state_q == S_NORMAL && |way_hit);
    assign cacop_ready_o = init_done_q && state_q == S_NORMAL && !lk_valid_q;
    assign cacop_fire    = cacop_valid_i && cacop_ready_o;
    assign req_ready_o   = init_done_q && state_q == S_NORMAL && !(lk_valid_q && !lk_hit)
                           && !(cacop_fire && cacop_op_i == icache_pkg::CACOP_HIT_INV);
    assign accept        = req_valid_i && req_ready_o;

    assign pkt_valid_o = lk_valid_q && lk_hit && !flush_i;
    assign pkt_o.pc    = lk_req_q.pc;
    assign pkt_o.mask  = lk_req_q.mask;
    assign pkt_o.insts = refill_done_q ? pkt_buf_q : (way_hit[1] ? data_rd[1] : data_rd[0]);

    assign mem_req_o  = state_q == S_MISS_REQ;
    assign mem_addr_o = {lk_req_q.pc[31:OFF_W], {OFF_W{1'b0}}};

    // tag port owner: init sweep, refill, or cacop
    always_comb begin
        tag_rw_idx = cacop_addr_q[OFF_W +: IDX_W];
        tag_wdata  = '0;
        tag_we     = '0;
        if (!init_done_q) begin
            tag_rw_idx = sweep_q;
            tag_we     = 2'b11;
        end else if (state_q == S_REFILL) begin
            tag_rw_idx     = miss_idx;
            tag_wdata      = '{valid: 1'b1, tag: lk_req_q.pc[31:OFF_W]};
            tag_we[victim] = refill_last;
        end else if (state_q == S_NORMAL) begin
            tag_rw_idx = cacop_addr_i[OFF_W +: IDX_W];
            tag_we[cacop_addr_i[0]] = cacop_fire && cacop_op_i == icache_pkg::CACOP_IDX_INV;
        end else if (state_q == S_CACOP_WR) begin
            tag_we = cacop_hit;
        end
    end

    // a pair is written on every odd word
    always_comb begin
        data_we         = '0;
        data_we[victim] = state_q == S_REFILL && mem_data_valid_i && word_cnt_q[0];
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_NORMAL: begin
                if (cacop_fire && cacop_op_i == icache_pkg::CACOP_HIT_INV) begin
                    state_d = S_CACOP_RD;
                end else if (lk_valid_q && !lk_hit && !flush_i) begin
                    state_d = S_MISS_REQ;
                end
            end
            S_MISS_REQ: begin
                if (mem_ack_i) begin
                    state_d = S_REFILL;
                end
            end
            S_REFILL: begin
                if (refill_last) begin
                    state_d = S_NORMAL;
                end
            end
            S_CACOP_RD: state_d = S_CACOP_WR;
            S_CACOP_WR: state_d = S_NORMAL;
            default:    state_d = S_NORMAL;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q       <= S_NORMAL;
            lk_valid_q    <= 1'b0;
            refill_done_q <= 1'b0;
            word_cnt_q    <= '0;
            repl_q        <= '0;
            sweep_q       <= '0;
            init_done_q   <= 1'b0;
        end else begin
            state_q       <= state_d;
            refill_done_q <= refill_last;
            if (flush_i) begin
                lk_valid_q <= 1'b0;
            end else if (accept) begin
                lk_valid_q <= 1'b1;
            end else if (lk_valid_q && lk_hit) begin
                lk_valid_q <= 1'b0;
            end
            if (!init_done_q) begin
                sweep_q     <= sweep_q + 1'b1;
                init_done_q <= sweep_q == IDX_W'(SET_NUM - 1);
            end
            if (state_q == S_MISS_REQ) begin
                word_cnt_q <= '0;
            end else if (state_q == S_REFILL && mem_data_valid_i) begin
                word_cnt_q <= word_cnt_q + 1'b1;
            end
            // next refill of this set goes to the other way
            if (refill_last) begin
                repl_q[miss_idx] <= !victim;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            lk_req_q <= req_i;
        end
        if (cacop_fire) begin
            cacop_addr_q <= cacop_addr_i;
        end
        if (state_q == S_REFILL && mem_data_valid_i) begin
            if (!word_cnt_q[0]) begin
                pair_lo_q <= mem_data_i;
            end else if (word_cnt_q[CNT_W-1:1] == lk_req_q.pc[3 +: PAIR_W]) begin
                // keep the pair the missed request asked for
                pkt_buf_q <= data_wdata;
            end
        end
    end

endmodule

//--- icache_fetch.f
icache_pkg.sv
cache_ram.sv
fetch_pc_gen.sv
icache.sv
inst_buffer.sv
icache_top.sv
icache_props.sv
tb_icache_top.sv

//--- icache_pkg.sv
package icache_pkg;

    // line geometry
    localparam int unsigned LINE_BYTES = 32;
    localparam int unsigned LINE_WORDS = 8;

    // fetch request, pc is 8-byte aligned except bit 2
    typedef struct packed {
        logic [31:0] pc;
        logic [1:0]  mask;
    } fetch_req_t;

    // insts[0] is the word at the aligned pair address
    typedef struct packed {
        logic [31:0]      pc;
        logic [1:0]       mask;
        logic [1:0][31:0] insts;
    } fetch_pkt_t;

    // full-width tag, address bits 31 to 5
    typedef struct packed {
        logic        valid;
        logic [26:0] tag;
    } cache_tag_t;

    typedef enum logic [0:0] {
        CACOP_IDX_INV,
        CACOP_HIT_INV
    } cacop_op_e;

endpackage

//--- icache_props.sv
`timescale 1ns/1ps

module icache_props (
    input logic        clk,
    input logic        rst_n,
    input logic        redirect_i,
    input logic        mem_req_i,
    input logic [31:0] mem_addr_i,
    input logic        mem_ack_i,
    input logic        out_valid_i
);

    localparam int unsigned OFF_W = $clog2(icache_pkg::LINE_BYTES);

    a_line_aligned: assert property (
        @(posedge clk) disable iff (!rst_n)
        mem_req_i |-> mem_addr_i[OFF_W-1:0] == '0
    ) else $error("memory request address is not line aligned");

    // request level holds with the same address until acked
    a_req_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        mem_req_i && !mem_ack_i |=> mem_req_i && $stable(mem_addr_i)
    ) else $error("memory request dropped or changed address before ack");

    a_flush_empty: assert property (
        @(posedge clk) disable iff (!rst_n)
        redirect_i |=> !out_valid_i
    ) else $error("decoder output valid in the cycle after a redirect");

endmodule

bind icache_top icache_props i_icache_props (
    .clk         (clk),
    .rst_n       (rst_n),
    .redirect_i  (redirect_i),
    .mem_req_i   (mem_req_o),
    .mem_addr_i  (mem_addr_o),
    .mem_ack_i   (mem_ack_i),
    .out_valid_i (out_valid_o)
);

//--- icache_top.sv
`timescale 1ns/1ps

module icache_top #(
    parameter int unsigned SET_NUM  = 128,
    parameter int unsigned IB_DEPTH = 4
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   redirect_i,
    input  logic [31:0]            redirect_pc_i,
    output logic                   mem_req_o,
    output logic [31:0]            mem_addr_o,
    input  logic                   mem_ack_i,
    input  logic                   mem_data_valid_i,
    input  logic [31:0]            mem_data_i,
    input  logic                   cacop_valid_i,
    input  icache_pkg::cacop_op_e  cacop_op_i,
    input  logic [31:0]            cacop_addr_i,
    output logic                   cacop_ready_o,
    output logic                   out_valid_o,
    output icache_pkg::fetch_pkt_t out_pkt_o,
    input  logic                   deq_i
);

    icache_pkg::fetch_req_t req;
    icache_pkg::fetch_pkt_t pkt;
    logic                   req_valid;
    logic                   req_ready;
    logic                   pkt_valid;
    logic                   space;

    fetch_pc_gen u_pc_gen (
        .clk           (clk),
        .rst_n         (rst_n),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .req_ready_i   (req_ready),
        .space_i       (space),
        .req_o         (req),
        .req_valid_o   (req_valid)
    );

    icache #(.SET_NUM(SET_NUM)) u_icache (
        .clk              (clk),
        .rst_n            (rst_n),
        .flush_i          (redirect_i),
        .req_i            (req),
        .req_valid_i      (req_valid),
        .req_ready_o      (req_ready),
        .pkt_o            (pkt),
        .pkt_valid_o      (pkt_valid),
        .mem_req_o        (mem_req_o),
        .mem_addr_o       (mem_addr_o),
        .mem_ack_i        (mem_ack_i),
        .mem_data_valid_i (mem_data_valid_i),
        .mem_data_i       (mem_data_i),
        .cacop_valid_i    (cacop_valid_i),
        .cacop_op_i       (cacop_op_i),
        .cacop_addr_i     (cacop_addr_i),
        .cacop_ready_o    (cacop_ready_o)
    );

    inst_buffer #(.IB_DEPTH(IB_DEPTH)) u_inst_buffer (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush_i     (redirect_i),
        .push_i      (pkt_valid),
        .pkt_i       (pkt),
        .space_o     (space),
        .out_valid_o (out_valid_o),
        .out_pkt_o   (out_pkt_o),
        .deq_i       (deq_i)
    );

endmodule

//--- inst_buffer.sv
`timescale 1ns/1ps

module inst_buffer #(
    parameter int unsigned IB_DEPTH = 4
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   flush_i,
    input  logic                   push_i,
    input  icache_pkg::fetch_pkt_t pkt_i,
    output logic                   space_o,
    output logic                   out_valid_o,
    output icache_pkg::fetch_pkt_t out_pkt_o,
    input  logic                   deq_i
);

    localparam int unsigned PTR_W = $clog2(IB_DEPTH);
    localparam int unsigned CNT_W = $clog2(IB_DEPTH + 1);

    icache_pkg::fetch_pkt_t mem_q [IB_DEPTH];
    logic [PTR_W-1:0]       head_q, tail_q;
    logic [CNT_W-1:0]       count_q;
    logic                   pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(IB_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign out_valid_o = count_q != '0;
    assign out_pkt_o   = mem_q[head_q];
    assign pop         = deq_i && out_valid_o;

    // room for the lookup in flight and one more request
    assign space_o = count_q < CNT_W'(IB_DEPTH - 1);

    always_ff @(posedge clk) begin
        if (!rst_n || flush_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (push_i) begin
                tail_q <= ptr_inc(tail_q);
            end
            if (pop) begin
                head_q <= ptr_inc(head_q);
            end
            case ({push_i, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) begin
            mem_q[tail_q] <= pkt_i;
        end
    end

endmodule

//--- run.sh
#!/usr/bin/env bash
# build and run the instruction-fetch testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_icache_top \
    -f icache_fetch.f \
    -o sim_icache

./obj_dir/sim_icache

//--- tb_icache_top.sv
`timescale 1ns/1ps

module tb_icache_top;

    localparam int          TIMEOUT  = 2000;
    // A, B and C share set 40, the odd pc sits in set 22
    localparam logic [31:0] LINE_A   = 32'h0002_0500;
    localparam logic [31:0] LINE_B   = 32'h0002_1500;
    localparam logic [31:0] LINE_C   = 32'h0002_2500;
    localparam logic [31:0] ODD_PC   = 32'h0000_02C4;
    localparam logic [31:0] ODD_LINE = 32'h0000_02C0;

    logic                   clk = 1'b0;
    logic                   rst_n = 1'b0;
    logic                   redirect_i = 1'b0;
    logic [31:0]            redirect_pc_i = '0;
    logic                   mem_req_o;
    logic [31:0]            mem_addr_o;
    logic                   mem_ack_i = 1'b0;
    logic                   mem_data_valid_i = 1'b0;
    logic [31:0]            mem_data_i = '0;
    logic                   cacop_valid_i = 1'b0;
    icache_pkg::cacop_op_e  cacop_op_i = icache_pkg::CACOP_IDX_INV;
    logic [31:0]            cacop_addr_i = '0;
    logic                   cacop_ready_o;
    logic                   out_valid_o;
    icache_pkg::fetch_pkt_t out_pkt_o;
    logic                   deq_i = 1'b0;

    string       test_name = "reset";
    logic [31:0] exp_pc;
    logic [31:0] req_log [$];
    logic        mem_busy;
    logic [31:0] line_addr;
    int unsigned word_idx;
    int unsigned gap;
    int unsigned seed_init;

    icache_top #(.SET_NUM(128), .IB_DEPTH(4)) i_icache_top (.*);

    initial begin
        forever #4 clk = ~clk;
    end

    // memory contents
    function automatic logic [31:0] rule_word(input logic [31:0] addr);
        return addr ^ 32'h5A5A_0000;
    endfunction

    function automatic bit logged_since(input int start, input logic [31:0] addr);
        for (int i = start; i < req_log.size(); i++) begin
            if (req_log[i] == addr) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        assert (act_v == exp_v) else begin
            $display("MISMATCH %s %s: expected %08h, actual %08h", test_name, what, exp_v, act_v);
            $display("TESTS FAILED");
            $fatal(1);
        end
    endtask

    // scoreboard of the decoder port
    always @(posedge clk) begin
        if (!rst_n) begin
            exp_pc = '0;
        end else if (redirect_i) begin
            exp_pc = redirect_pc_i & 32'hFFFF_FFFC;
        end else if (out_valid_o && deq_i) begin
            check_value("pc", exp_pc, out_pkt_o.pc);
            check_value("mask", exp_pc[2] ? 32'd2 : 32'd3, 32'(out_pkt_o.mask));
            check_value("inst0", rule_word({exp_pc[31:3], 3'b000}), out_pkt_o.insts[0]);
            check_value("inst1", rule_word({exp_pc[31:3], 3'b100}), out_pkt_o.insts[1]);
            // step to the next 8-byte boundary
            exp_pc = (exp_pc & 32'hFFFF_FFF8) + 32'd8;
        end
    end

    // one ack, then eight words, random gaps everywhere
    always @(posedge clk) begin
        mem_ack_i        <= 1'b0;
        mem_data_valid_i <= 1'b0;
        if (!rst_n) begin
            mem_busy = 1'b0;
            gap      = 0;
        end else if (gap != 0) begin
            gap = gap - 1;
        end else if (!mem_busy && mem_req_o) begin
            mem_ack_i <= 1'b1;
            line_addr = mem_addr_o;
            word_idx  = 0;
            mem_busy  = 1'b1;
            req_log.push_back(mem_addr_o);
            gap = $urandom % 3;
        end else if (mem_busy) begin
            mem_data_valid_i <= 1'b1;
            mem_data_i       <= rule_word(line_addr + 32'(word_idx * 4));
            word_idx = word_idx + 1;
            if (word_idx == 8) begin
                mem_busy = 1'b0;
            end
            gap = $urandom % 3;
        end
    end

    task automatic pop_packets(input int n, input bit stall);
        int got;
        int idle;
        got   = 0;
        idle  = 0;
        deq_i <= 1'b1;
        while (got < n) begin
            @(posedge clk);
            if (out_valid_o && deq_i) begin
                got++;
                idle = 0;
            end else begin
                idle++;
            end
            if (idle > TIMEOUT) begin
                fail_run("timeout: no packet reached the decoder port");
            end
            if (got == n) begin
                deq_i <= 1'b0;
            end else if (stall) begin
                deq_i <= ($urandom % 3 == 0);
            end else begin
                deq_i <= 1'b1;
            end
        end
    endtask

    task automatic redirect_to(input logic [31:0] pc);
        redirect_i    <= 1'b1;
        redirect_pc_i <= pc;
        deq_i         <= 1'b0;
        @(posedge clk);
        redirect_i <= 1'b0;
    endtask

    task automatic do_cacop(input icache_pkg::cacop_op_e op, input logic [31:0] addr);
        int waited;
        waited = 0;
        cacop_valid_i <= 1'b1;
        cacop_op_i    <= op;
        cacop_addr_i  <= addr;
        do begin
            @(posedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                fail_run("timeout: cacop request was never accepted");
            end
        end while (!cacop_ready_o);
        cacop_valid_i <= 1'b0;
    endtask

    initial begin
        int s;
        seed_init = $urandom(10);
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        test_name = "cold_fetch";
        pop_packets(32, 1'b0);
        assert (req_log.size() >= 8) else fail_run("cold fetch made fewer requests than lines");
        for (int i = 0; i < 8; i++) begin
            check_value("mem_addr", 32'(i * 32), req_log[i]);
        end

        test_name = "refetch_hit";
        s = req_log.size();
        redirect_to(32'h0);
        pop_packets(16, 1'b0);
        for (int i = 0; i < 6; i++) begin
            assert (!logged_since(s, 32'(i * 32)))
                else fail_run("a cached line was requested again after redirect");
        end

        test_name = "back_pressure";
        pop_packets(40, 1'b1);

        test_name = "odd_redirect";
        redirect_to(ODD_PC);
        pop_packets(6, 1'b1);

        // A, B, C fill set 40 in turn, so C evicts A
        test_name = "round_robin";
        redirect_to(LINE_A);
        pop_packets(4, 1'b0);
        redirect_to(LINE_B);
        pop_packets(4, 1'b0);
        redirect_to(LINE_C);
        pop_packets(4, 1'b0);
        s = req_log.size();
        redirect_to(LINE_B);
        pop_packets(4, 1'b0);
        assert (!logged_since(s, LINE_B)) else fail_run("line B missed while still cached");
        s = req_log.size();
        redirect_to(LINE_A);
        pop_packets(4, 1'b0);
        assert (logged_since(s, LINE_A)) else fail_run("line A hit after being evicted");

        // both ways of set 22
        test_name = "cacop_idx_inv";
        do_cacop(icache_pkg::CACOP_IDX_INV, ODD_LINE);
        do_cacop(icache_pkg::CACOP_IDX_INV, ODD_LINE | 32'd1);
        s = req_log.size();
        redirect_to(ODD_LINE);
        pop_packets(4, 1'b1);
        assert (logged_since(s, ODD_LINE)) else fail_run("line hit after index invalidate");

        test_name = "cacop_hit_inv";
        do_cacop(icache_pkg::CACOP_HIT_INV, LINE_A + 32'd12);
        s = req_log.size();
        redirect_to(LINE_A);
        pop_packets(4, 1'b1);
        assert (logged_since(s, LINE_A)) else fail_run("line hit after hit invalidate");

        repeat (10) @(posedge clk);
        $display("TESTS PASSED");
        $finish;
    end

endmodule
